//--- hw/pa_word_pkg.sv
// ======================================================================
// data word and half word types of the arithmetic unit datapath
// bit 0 is the most significant bit of every word
// ======================================================================

`default_nettype none

package pa_word_pkg;

	// machine word width, fixed by the architecture
	localparam int PA_WORD_W = 16;

	// full data word
	typedef logic [0:PA_WORD_W-1] pa_word_t;

	// upper or lower half of a word
	typedef logic [0:PA_WORD_W/2-1] pa_byte_t;

endpackage

`default_nettype wire

//--- hw/pa_op_pkg.sv
// ======================================================================
// ALU operation codes, logic function codes
// W bus and A bus source select codes
// ======================================================================

`default_nettype none

package pa_op_pkg;

	// ALU operation from the control unit
	typedef logic [2:0] pa_alu_op_t;

	localparam pa_alu_op_t OP_PASS_A = 3'd0;
	localparam pa_alu_op_t OP_ADD    = 3'd1;
	localparam pa_alu_op_t OP_SUB    = 3'd2;
	localparam pa_alu_op_t OP_AND    = 3'd3;
	localparam pa_alu_op_t OP_OR     = 3'd4;
	localparam pa_alu_op_t OP_XOR    = 3'd5;
	localparam pa_alu_op_t OP_INC_A  = 3'd6;

	// logic unit function, decoded from the operation
	typedef logic [1:0] pa_alu_fn_t;

	localparam pa_alu_fn_t FN_PASS = 2'd0;
	localparam pa_alu_fn_t FN_AND  = 2'd1;
	localparam pa_alu_fn_t FN_OR   = 2'd2;
	localparam pa_alu_fn_t FN_XOR  = 2'd3;

	// W bus source, unused codes put zero on the bus
	typedef logic [2:0] pa_wsel_t;

	localparam pa_wsel_t WS_KL  = 3'd0;
	localparam pa_wsel_t WS_RDT = 3'd1;
	localparam pa_wsel_t WS_IR  = 3'd2;
	localparam pa_wsel_t WS_AC  = 3'd3;
	localparam pa_wsel_t WS_AT  = 3'd4;
	localparam pa_wsel_t WS_F   = 3'd5;

	// A bus source
	typedef logic [1:0] pa_asel_t;

	localparam pa_asel_t AS_L        = 2'd0;
	localparam pa_asel_t AS_IR_SHORT = 2'd1;
	localparam pa_asel_t AS_AR       = 2'd2;
	localparam pa_asel_t AS_IC       = 2'd3;

endpackage

`default_nettype wire

//--- hw/pa_decode.sv
// ======================================================================
// strobe qualification by phase into register load and increment
// pulses, and operation code split into ALU controls
// ======================================================================

`timescale 1ns/1ps
`default_nettype none

module pa_decode (
	input  wire                    strob1,
	input  wire                    strob2,
	input  wire                    as2,
	input  wire                    w_ac,
	input  wire                    w_ar,
	input  wire                    w_ic,
	input  wire                    w_at,
	input  wire                    arp1,
	input  wire                    icp1,
	input  wire pa_op_pkg::pa_alu_op_t alu_op,
	output logic                   ac_ld,
	output logic                   ar_ld,
	output logic                   ar_inc,
	output logic                   ic_ld,
	output logic                   ic_inc,
	output logic                   at_ld,
	output logic                   wzi_ld,
	output logic                   alu_sub,
	output logic                   alu_logic,
	output pa_op_pkg::pa_alu_fn_t  alu_fn
);
	import pa_op_pkg::*;

	logic stroba;
	logic strobb;
	logic strob_q;

	// strob1 counts in phase 1, strob2 in phase 2
	assign stroba  = strob1 & ~as2;
	assign strobb  = strob2 & as2;
	assign strob_q = stroba | strobb;

	assign ac_ld = w_ac & strob_q;
	assign ar_ld = w_ar & strob_q;
	assign ic_ld = w_ic & strob_q;
	assign at_ld = w_at & strob_q;

	// AR steps only in phase 1, IC on any strob1
	assign ar_inc = arp1 & stroba;
	assign ic_inc = icp1 & strob1;
	assign wzi_ld = as2 & strob1;

	always_comb begin
		alu_sub   = 1'b0;
		alu_logic = 1'b1;
		alu_fn    = FN_PASS;
		case (alu_op)
			OP_ADD, OP_INC_A: alu_logic = 1'b0;
			OP_SUB: begin
				// invert a and force carry in
				alu_logic = 1'b0;
				alu_sub   = 1'b1;
			end
			OP_AND: alu_fn = FN_AND;
			OP_OR:  alu_fn = FN_OR;
			OP_XOR: alu_fn = FN_XOR;
			default: alu_fn = FN_PASS;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/pa_bus.sv
// ======================================================================
// W bus and A bus source multiplexers
// short argument built from ir by sign extension
// ======================================================================

`timescale 1ns/1ps
`default_nettype none

module pa_bus (
	input  wire pa_op_pkg::pa_wsel_t   w_sel,
	input  wire pa_op_pkg::pa_asel_t   a_sel,
	input  wire pa_word_pkg::pa_word_t ir,
	input  wire pa_word_pkg::pa_word_t kl,
	input  wire pa_word_pkg::pa_word_t rdt,
	input  wire pa_word_pkg::pa_word_t l,
	input  wire pa_word_pkg::pa_word_t ac,
	input  wire pa_word_pkg::pa_word_t at,
	input  wire pa_word_pkg::pa_word_t f,
	input  wire pa_word_pkg::pa_word_t ar,
	input  wire pa_word_pkg::pa_word_t ic,
	output pa_word_pkg::pa_word_t      w,
	output pa_word_pkg::pa_word_t      a
);
	import pa_word_pkg::*;
	import pa_op_pkg::*;

	pa_word_t ir_short;

	// low 6 bits of ir, sign in ir[10]
	assign ir_short = {{(PA_WORD_W-6){ir[10]}}, ir[10:15]};

	always_comb begin
		case (w_sel)
			WS_KL:   w = kl;
			WS_RDT:  w = rdt;
			WS_IR:   w = ir;
			WS_AC:   w = ac;
			WS_AT:   w = at;
			WS_F:    w = f;
			default: w = '0;
		endcase
	end

	always_comb begin
		case (a_sel)
			AS_L:        a = l;
			AS_IR_SHORT: a = ir_short;
			AS_AR:       a = ar;
			default:     a = ic;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/pa_alu.sv
// ======================================================================
// 16-bit execute unit: adder with optional operand inversion
// beside a logic unit, with carry, zero and true sign outputs
// ======================================================================

`timescale 1ns/1ps
`default_nettype none

module pa_alu (
	input  wire pa_word_pkg::pa_word_t a,
	input  wire pa_word_pkg::pa_word_t ac,
	input  wire                        carry_in,
	input  wire pa_op_pkg::pa_alu_op_t alu_op,
	input  wire                        alu_sub,
	input  wire                        alu_logic,
	input  wire pa_op_pkg::pa_alu_fn_t alu_fn,
	output pa_word_pkg::pa_word_t      f,
	output logic                       carry,
	output logic                       zsum,
	output logic                       s_1
);
	import pa_word_pkg::*;
	import pa_op_pkg::*;

	pa_word_t             op_a;
	pa_word_t             op_ac;
	pa_word_t             f_logic;
	logic                 cin;
	logic                 ovf;
	logic [0:PA_WORD_W]   sum;

	// adder operands, ac reads as zero for the increment
	assign op_a  = alu_sub ? ~a : a;
	assign op_ac = (alu_op == OP_INC_A) ? '0 : ac;

	always_comb begin
		if (alu_sub || alu_op == OP_INC_A)
			cin = 1'b1;
		else if (alu_op == OP_ADD)
			cin = carry_in;
		else
			cin = 1'b0;
	end

	// sum[0] is the carry out
	assign sum = {1'b0, op_ac} + {1'b0, op_a} + {{PA_WORD_W{1'b0}}, cin};

	// equal operand signs, different result sign
	assign ovf = (op_ac[0] == op_a[0]) & (sum[1] != op_ac[0]);

	always_comb begin
		case (alu_fn)
			FN_AND:  f_logic = ac & a;
			FN_OR:   f_logic = ac | a;
			FN_XOR:  f_logic = ac ^ a;
			default: f_logic = a;
		endcase
	end

	assign f     = alu_logic ? f_logic : sum[1:PA_WORD_W];
	assign carry = ~alu_logic & sum[0];
	assign zsum  = (f == '0);
	assign s_1   = alu_logic ? f[0] : (f[0] ^ ovf);

endmodule

`default_nettype wire

//--- hw/pa_regs.sv
// ======================================================================
// working registers AC, AR, IC and AT
// load from W (AT from the ALU result), increment and clear
// ======================================================================

`timescale 1ns/1ps
`default_nettype none

module pa_regs (
	input  wire                        __clk,
	input  wire                        rst_n,
	input  wire pa_word_pkg::pa_word_t w,
	input  wire pa_word_pkg::pa_word_t f,
	input  wire                        ac_ld,
	input  wire                        ar_ld,
	input  wire                        ar_inc,
	input  wire                        ic_ld,
	input  wire                        ic_inc,
	input  wire                        off,
	input  wire                        at_ld,
	output pa_word_pkg::pa_word_t      ac,
	output pa_word_pkg::pa_word_t      ar,
	output pa_word_pkg::pa_word_t      ic,
	output pa_word_pkg::pa_word_t      at
);
	import pa_word_pkg::*;

	// accumulator
	always_ff @(posedge __clk) begin
		if (!rst_n)
			ac <= '0;
		else if (ac_ld)
			ac <= w;
	end

	// argument address, load over increment
	always_ff @(posedge __clk) begin
		if (!rst_n)
			ar <= '0;
		else if (ar_ld)
			ar <= w;
		else if (ar_inc)
			ar <= ar + pa_word_t'(1);
	end

	// instruction counter: off, then load, then increment
	always_ff @(posedge __clk) begin
		if (!rst_n)
			ic <= '0;
		else if (off)
			ic <= '0;
		else if (ic_ld)
			ic <= w;
		else if (ic_inc)
			ic <= ic + pa_word_t'(1);
	end

	// auxiliary register takes the ALU result
	always_ff @(posedge __clk) begin
		if (!rst_n)
			at <= '0;
		else if (at_ld)
			at <= f;
	end

endmodule

`default_nettype wire

//--- hw/pa_result.sv
// ======================================================================
// adder zero indicator WZI and zero-sign flag
// memory address output with keyboard address match
// ======================================================================

`timescale 1ns/1ps
`default_nettype none

module pa_result (
	input  wire                        __clk,
	input  wire                        rst_n,
	input  wire                        wzi_ld,
	input  wire                        zsum,
	input  wire                        s_1,
	input  wire pa_word_pkg::pa_word_t f,
	input  wire pa_word_pkg::pa_word_t ar,
	input  wire pa_word_pkg::pa_word_t ic,
	input  wire                        ar_ad,
	input  wire                        ic_ad,
	input  wire pa_word_pkg::pa_word_t kl,
	input  wire                        barnb,
	output logic                       s0,
	output logic                       zs,
	output logic                       wzi,
	output pa_word_pkg::pa_word_t      dad,
	output logic                       zga,
	output logic                       ar_hi_nz
);
	import pa_word_pkg::*;

	pa_byte_t ar_hi;

	assign s0 = f[0];

	// zero and not negative
	assign zs = zsum & ~s_1;

	always_ff @(posedge __clk) begin
		if (!rst_n)
			wzi <= 1'b0;
		else if (wzi_ld)
			wzi <= zs;
	end

	assign dad = (ar & {PA_WORD_W{ar_ad}}) | (ic & {PA_WORD_W{ic_ad}});

	// barnb stands in for the top address bit
	assign zga = (kl == {barnb, dad[1:PA_WORD_W-1]});

	assign ar_hi    = ar[0:PA_WORD_W/2-1];
	assign ar_hi_nz = |ar_hi;

endmodule

`default_nettype wire

//--- hw/pa.sv
// ======================================================================
// arithmetic unit top level: decode, buses, execute unit,
// working registers and result flags
// ======================================================================

`timescale 1ns/1ps
`default_nettype none

module pa (
	input  wire                        __clk,
	input  wire                        rst_n,
	// data words
	input  wire pa_word_pkg::pa_word_t ir,
	input  wire pa_word_pkg::pa_word_t kl,
	input  wire pa_word_pkg::pa_word_t rdt,
	input  wire pa_word_pkg::pa_word_t l,
	// source selects and operation
	input  wire pa_op_pkg::pa_wsel_t   w_sel,
	input  wire pa_op_pkg::pa_asel_t   a_sel,
	input  wire pa_op_pkg::pa_alu_op_t alu_op,
	input  wire                        carry_in,
	// strobes and phase
	input  wire                        strob1,
	input  wire                        strob2,
	input  wire                        as2,
	// write enables
	input  wire                        w_ac,
	input  wire                        w_ar,
	input  wire                        w_ic,
	input  wire                        w_at,
	input  wire                        arp1,
	input  wire                        icp1,
	input  wire                        off,
	// address controls
	input  wire                        ar_ad,
	input  wire                        ic_ad,
	input  wire                        barnb,
	output pa_word_pkg::pa_word_t      w,
	output pa_word_pkg::pa_word_t      dad,
	output logic                       s0,
	output logic                       carry,
	output logic                       zs,
	output logic                       wzi,
	output logic                       ar_hi_nz,
	output logic                       zga,
	output logic                       at15
);
	import pa_word_pkg::*;
	import pa_op_pkg::*;

	logic       ac_ld, ar_ld, ar_inc, ic_ld, ic_inc, at_ld, wzi_ld;
	logic       alu_sub, alu_logic;
	pa_alu_fn_t alu_fn;
	pa_word_t   a, f;
	pa_word_t   ac, ar, ic, at;
	logic       zsum, s_1;

	pa_decode u_decode (
		.strob1(strob1), .strob2(strob2), .as2(as2),
		.w_ac(w_ac), .w_ar(w_ar), .w_ic(w_ic), .w_at(w_at),
		.arp1(arp1), .icp1(icp1), .alu_op(alu_op),
		.ac_ld(ac_ld), .ar_ld(ar_ld), .ar_inc(ar_inc),
		.ic_ld(ic_ld), .ic_inc(ic_inc), .at_ld(at_ld), .wzi_ld(wzi_ld),
		.alu_sub(alu_sub), .alu_logic(alu_logic), .alu_fn(alu_fn)
	);

	pa_bus u_bus (
		.w_sel(w_sel), .a_sel(a_sel),
		.ir(ir), .kl(kl), .rdt(rdt), .l(l),
		.ac(ac), .at(at), .f(f), .ar(ar), .ic(ic),
		.w(w), .a(a)
	);

	pa_alu u_alu (
		.a(a), .ac(ac), .carry_in(carry_in), .alu_op(alu_op),
		.alu_sub(alu_sub), .alu_logic(alu_logic), .alu_fn(alu_fn),
		.f(f), .carry(carry), .zsum(zsum), .s_1(s_1)
	);

	pa_regs u_regs (
		.__clk(__clk), .rst_n(rst_n), .w(w), .f(f),
		.ac_ld(ac_ld), .ar_ld(ar_ld), .ar_inc(ar_inc),
		.ic_ld(ic_ld), .ic_inc(ic_inc), .off(off), .at_ld(at_ld),
		.ac(ac), .ar(ar), .ic(ic), .at(at)
	);

	pa_result u_result (
		.__clk(__clk), .rst_n(rst_n), .wzi_ld(wzi_ld),
		.zsum(zsum), .s_1(s_1), .f(f), .ar(ar), .ic(ic),
		.ar_ad(ar_ad), .ic_ad(ic_ad), .kl(kl), .barnb(barnb),
		.s0(s0), .zs(zs), .wzi(wzi), .dad(dad),
		.zga(zga), .ar_hi_nz(ar_hi_nz)
	);

	// least significant bit of AT
	assign at15 = at[PA_WORD_W-1];

endmodule

`default_nettype wire

//--- tests/pa_assertions.sv
// ======================================================================
// concurrent checks on the working registers, bound to pa_regs:
// clear after reset, IC clear by off, load over increment
// ======================================================================

`timescale 1ns/1ps
`default_nettype none

module pa_assertions (
	input wire                        __clk,
	input wire                        rst_n,
	input wire pa_word_pkg::pa_word_t w,
	input wire                        ar_ld,
	input wire                        ar_inc,
	input wire                        ic_ld,
	input wire                        ic_inc,
	input wire                        off,
	input wire pa_word_pkg::pa_word_t ac,
	input wire pa_word_pkg::pa_word_t ar,
	input wire pa_word_pkg::pa_word_t ic,
	input wire pa_word_pkg::pa_word_t at
);

	// failed assertions so far, read by the testbench at the end
	int unsigned fail_count = 0;

	property reset_clears;
		@(posedge __clk) !rst_n |=> (ac == '0 && ar == '0 && ic == '0 && at == '0);
	endproperty

	property off_clears_ic;
		@(posedge __clk) off |=> (ic == '0);
	endproperty

	// load beats a simultaneous increment
	property ar_load_first;
		@(posedge __clk) (rst_n && ar_ld && ar_inc) |=> (ar == $past(w));
	endproperty

	property ic_load_first;
		@(posedge __clk) (rst_n && !off && ic_ld && ic_inc) |=> (ic == $past(w));
	endproperty

	assert property (reset_clears) else begin
		fail_count++;
		$error("registers not zero in the cycle after reset");
	end

	assert property (off_clears_ic) else begin
		fail_count++;
		$error("off did not clear IC");
	end

	assert property (ar_load_first) else begin
		fail_count++;
		$error("AR increment took priority over load");
	end

	assert property (ic_load_first) else begin
		fail_count++;
		$error("IC increment took priority over load");
	end

endmodule

bind pa_regs pa_assertions u_assertions (
	.__clk(__clk), .rst_n(rst_n), .w(w),
	.ar_ld(ar_ld), .ar_inc(ar_inc), .ic_ld(ic_ld), .ic_inc(ic_inc), .off(off),
	.ac(ac), .ar(ar), .ic(ic), .at(at)
);

`default_nettype wire

//--- tests/pa_tb.sv
// ======================================================================
// testbench for the arithmetic unit with clock, reset, random stimulus,
// reference ALU function, register model, compare tasks and report
// ======================================================================

`timescale 1ns/1ps
`default_nettype none

module pa_tb;
	import pa_word_pkg::*;
	import pa_op_pkg::*;

	// ample margin over the cycles the tests need
	localparam int TIMEOUT_CYCLES = 3000;

	logic       __clk = 1'b0;
	logic       rst_n;
	pa_word_t   ir, kl, rdt, l;
	pa_wsel_t   w_sel;
	pa_asel_t   a_sel;
	pa_alu_op_t alu_op;
	logic       carry_in, strob1, strob2, as2;
	logic       w_ac, w_ar, w_ic, w_at, arp1, icp1, off;
	logic       ar_ad, ic_ad, barnb;
	pa_word_t   w, dad;
	logic       s0, carry, zs, wzi, ar_hi_nz, zga, at15;

	// register model and expected outputs
	pa_word_t    m_ac, m_ar, m_ic, m_at;
	logic        m_wzi;
	pa_word_t    exp_a, exp_f, exp_w, exp_dad, short_arg;
	logic        exp_carry, exp_s1, exp_zs, exp_zga, exp_hi_nz;
	logic [17:0] ref_out;
	logic        q_strobe, ph1_strobe;
	logic        after_reset;

	int          seed = 32'haf5c;
	int          value_errors = 0;
	int unsigned cycles = 0;

	always #4 __clk = ~__clk;

	pa UUT (.*);

	// returns {carry, true sign, result} for 16-bit two's complement words
	function automatic logic [17:0] pa_ref_alu(input pa_alu_op_t op, input pa_word_t a,
			input pa_word_t ac, input logic cin);
		logic [15:0] ua;
		logic [15:0] uac;
		logic [15:0] res;
		logic [16:0] usum;
		logic [16:0] wide;
		logic        c;
		logic        s;
		ua = a;
		uac = ac;
		usum = '0;
		wide = '0;
		c = 1'b0;
		case (op)
			OP_ADD: begin
				usum = {1'b0, uac} + {1'b0, ua} + {16'd0, cin};
				wide = {uac[15], uac} + {ua[15], ua} + {16'd0, cin};
				res = usum[15:0];
				c = usum[16];
			end
			OP_SUB: begin
				res = uac - ua;
				// no borrow
				c = (uac >= ua);
				wide = {uac[15], uac} - {ua[15], ua};
			end
			OP_INC_A: begin
				res = ua + 16'd1;
				c = (ua == 16'hffff);
				wide = {ua[15], ua} + 17'd1;
			end
			OP_AND: res = uac & ua;
			OP_OR:  res = uac | ua;
			OP_XOR: res = uac ^ ua;
			default: res = ua;
		endcase
		if (op == OP_ADD || op == OP_SUB || op == OP_INC_A)
			s = wide[16];
		else
			s = res[15];
		return {c, s, res};
	endfunction

	always_comb begin
		short_arg = ir & 16'h003f;
		if (short_arg[10])
			short_arg = short_arg | 16'hffc0;
		case (a_sel)
			AS_L:        exp_a = l;
			AS_IR_SHORT: exp_a = short_arg;
			AS_AR:       exp_a = m_ar;
			default:     exp_a = m_ic;
		endcase
		ref_out = pa_ref_alu(alu_op, exp_a, m_ac, carry_in);
		exp_f = ref_out[15:0];
		exp_s1 = ref_out[16];
		exp_carry = ref_out[17];
		exp_zs = (exp_f == '0) && !exp_s1;
		case (w_sel)
			WS_KL:   exp_w = kl;
			WS_RDT:  exp_w = rdt;
			WS_IR:   exp_w = ir;
			WS_AC:   exp_w = m_ac;
			WS_AT:   exp_w = m_at;
			WS_F:    exp_w = exp_f;
			default: exp_w = '0;
		endcase
		exp_dad = (ar_ad ? m_ar : '0) | (ic_ad ? m_ic : '0);
		exp_zga = (kl == {barnb, exp_dad[1:15]});
		exp_hi_nz = (m_ar[0:7] != 8'h00);
		q_strobe = (strob1 && !as2) || (strob2 && as2);
		ph1_strobe = strob1 && !as2;
	end

	// model registers follow the pulse rules
	always @(posedge __clk) begin
		if (!rst_n) begin
			m_ac <= '0;
			m_ar <= '0;
			m_ic <= '0;
			m_at <= '0;
			m_wzi <= 1'b0;
		end else begin
			if (w_ac && q_strobe)
				m_ac <= exp_w;
			if (w_ar && q_strobe)
				m_ar <= exp_w;
			else if (arp1 && ph1_strobe)
				m_ar <= m_ar + 16'd1;
			if (off)
				m_ic <= '0;
			else if (w_ic && q_strobe)
				m_ic <= exp_w;
			else if (icp1 && strob1)
				m_ic <= m_ic + 16'd1;
			if (w_at && q_strobe)
				m_at <= exp_f;
			if (as2 && strob1)
				m_wzi <= exp_zs;
		end
	end

	task automatic check_word(input string what, input pa_word_t got, input pa_word_t want);
		if (got !== want) begin
			value_errors++;
			$display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic want);
		if (got !== want) begin
			value_errors++;
			$display("FAILED at %0d ns: %s is %b, expected %b", $time, what, got, want);
		end
	endtask

	// outputs are settled by the falling edge
	always @(negedge __clk) begin
		if (rst_n) begin
			check_word("w", w, exp_w);
			check_word("dad", dad, exp_dad);
			check_bit("s0", s0, exp_f[0]);
			check_bit("carry", carry, exp_carry);
			check_bit("zs", zs, exp_zs);
			check_bit("wzi", wzi, m_wzi);
			check_bit("zga", zga, exp_zga);
			check_bit("ar_hi_nz", ar_hi_nz, exp_hi_nz);
			check_bit("at15", at15, m_at[15]);
			if (after_reset) begin
				check_word("w after reset", w, '0);
				check_word("dad after reset", dad, '0);
				check_bit("wzi after reset", wzi, 1'b0);
				check_bit("at15 after reset", at15, 1'b0);
			end
		end
	end

	always @(posedge __clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("ERROR: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("errors: %0d value mismatches, %0d assertion failures",
				value_errors, UUT.u_regs.u_assertions.fail_count);
			$display("=== FAIL ===");
			$finish;
		end
	end

	function automatic pa_word_t rand_word();
		return pa_word_t'($random(seed));
	endfunction

	task automatic idle_controls();
		strob1 <= 1'b0;
		strob2 <= 1'b0;
		as2 <= 1'b0;
		w_ac <= 1'b0;
		w_ar <= 1'b0;
		w_ic <= 1'b0;
		w_at <= 1'b0;
		arp1 <= 1'b0;
		icp1 <= 1'b0;
		off <= 1'b0;
	endtask

	// which picks 0 AC, 1 AR, 2 IC, else AT
	task automatic strobe_write(input int which, input pa_wsel_t src, input pa_word_t value,
			input logic phase, input logic use_strob2);
		@(posedge __clk);
		idle_controls();
		case (src)
			WS_KL:   kl <= value;
			WS_RDT:  rdt <= value;
			default: ir <= value;
		endcase
		w_sel <= src;
		as2 <= phase;
		strob1 <= !use_strob2;
		strob2 <= use_strob2;
		case (which)
			0:       w_ac <= 1'b1;
			1:       w_ar <= 1'b1;
			2:       w_ic <= 1'b1;
			default: w_at <= 1'b1;
		endcase
	endtask

	// AC on W, then AR and IC on dad
	task automatic read_back();
		@(posedge __clk);
		idle_controls();
		w_sel <= WS_AC;
		ar_ad <= 1'b1;
		ic_ad <= 1'b0;
		@(posedge __clk);
		ar_ad <= 1'b0;
		ic_ad <= 1'b1;
	endtask

	task automatic step_counters(input logic ar_step, input logic ic_step, input logic phase,
			input logic use_strob2);
		@(posedge __clk);
		idle_controls();
		arp1 <= ar_step;
		icp1 <= ic_step;
		as2 <= phase;
		strob1 <= !use_strob2;
		strob2 <= use_strob2;
		ar_ad <= ar_step;
		ic_ad <= ic_step;
	endtask

	task automatic run_register_loads();
		pa_wsel_t src;
		for (int i = 0; i < 4; i++) begin
			for (int which = 0; which < 3; which++) begin
				case (i % 3)
					0:       src = WS_KL;
					1:       src = WS_RDT;
					default: src = WS_IR;
				endcase
				strobe_write(which, src, rand_word(), 1'b0, 1'b0);
				read_back();
				strobe_write(which, src, rand_word(), 1'b1, 1'b1);
				read_back();
				// strobe of the other phase
				strobe_write(which, src, rand_word(), 1'b0, 1'b1);
				read_back();
				strobe_write(which, src, rand_word(), 1'b1, 1'b0);
				read_back();
			end
		end
	endtask

	task automatic run_alu_ops();
		int unsigned r;
		pa_word_t    acv;
		for (int i = 0; i < 200; i++) begin
			if (i % 20 == 0) begin
				strobe_write(1, WS_RDT, rand_word(), 1'b0, 1'b0);
				strobe_write(2, WS_KL, rand_word(), 1'b1, 1'b1);
			end
			acv = rand_word();
			// most negative word doubled overflows to a zero sum
			if (i % 50 == 25)
				acv = 16'h8000;
			strobe_write(0, WS_RDT, acv, 1'b0, 1'b0);
			@(posedge __clk);
			idle_controls();
			r = $random(seed);
			l <= rand_word();
			ir <= rand_word();
			a_sel <= pa_asel_t'(i % 4);
			alu_op <= pa_alu_op_t'(r % 7);
			carry_in <= r[8];
			w_sel <= WS_F;
			// equal operands now and then give a zero result
			if (i % 8 == 7) begin
				l <= acv;
				a_sel <= AS_L;
				alu_op <= OP_SUB;
			end
			if (i % 50 == 25) begin
				l <= acv;
				a_sel <= AS_L;
				alu_op <= OP_ADD;
				carry_in <= 1'b0;
			end
		end
	endtask

	task automatic run_at_and_wzi();
		pa_word_t acv;
		for (int i = 0; i < 16; i++) begin
			acv = rand_word();
			strobe_write(0, WS_KL, acv, 1'b0, 1'b0);
			@(posedge __clk);
			idle_controls();
			l <= (i % 2 == 0) ? acv : rand_word();
			a_sel <= AS_L;
			alu_op <= (i % 4 < 2) ? OP_SUB : OP_XOR;
			w_sel <= WS_F;
			w_at <= 1'b1;
			as2 <= (i % 3 == 0);
			strob1 <= 1'b1;
			strob2 <= 1'b1;
			@(posedge __clk);
			idle_controls();
			w_sel <= WS_AT;
		end
	endtask

	task automatic run_increments();
		strobe_write(1, WS_RDT, 16'h00fe, 1'b0, 1'b0);
		step_counters(1'b1, 1'b0, 1'b0, 1'b0);
		step_counters(1'b1, 1'b0, 1'b1, 1'b0);
		step_counters(1'b1, 1'b0, 1'b1, 1'b1);
		step_counters(1'b1, 1'b0, 1'b0, 1'b0);
		strobe_write(1, WS_KL, 16'h1234, 1'b0, 1'b0);
		arp1 <= 1'b1;
		// IC wraps from all ones
		strobe_write(2, WS_RDT, 16'hfffe, 1'b0, 1'b0);
		step_counters(1'b0, 1'b1, 1'b0, 1'b0);
		step_counters(1'b0, 1'b1, 1'b1, 1'b0);
		step_counters(1'b0, 1'b1, 1'b1, 1'b1);
		strobe_write(2, WS_IR, 16'h0f0f, 1'b1, 1'b1);
		icp1 <= 1'b1;
		strob1 <= 1'b1;
		strobe_write(2, WS_KL, 16'h5555, 1'b0, 1'b0);
		off <= 1'b1;
		read_back();
	endtask

	task automatic run_address_match();
		pa_word_t    arv;
		pa_word_t    icv;
		pa_word_t    sel;
		int unsigned r;
		for (int i = 0; i < 100; i++) begin
			arv = rand_word();
			if (i % 3 == 0)
				arv = arv & 16'h00ff;
			icv = rand_word();
			strobe_write(1, WS_RDT, arv, 1'b0, 1'b0);
			strobe_write(2, WS_RDT, icv, 1'b1, 1'b1);
			@(posedge __clk);
			idle_controls();
			r = $random(seed);
			sel = (i % 2 == 0) ? arv : icv;
			ar_ad <= (i % 2 == 0);
			ic_ad <= (i % 2 != 0);
			barnb <= r[0];
			// half the passes match and a quarter differ only in bit 0
			if (i % 4 < 2)
				kl <= {r[0], sel[1:15]};
			else if (i % 4 == 2)
				kl <= {~r[0], sel[1:15]};
			else
				kl <= rand_word();
		end
	endtask

	initial begin
		rst_n <= 1'b0;
		after_reset <= 1'b1;
		ir <= '0;
		kl <= '0;
		rdt <= '0;
		l <= '0;
		w_sel <= WS_AC;
		a_sel <= AS_L;
		alu_op <= OP_PASS_A;
		carry_in <= 1'b0;
		idle_controls();
		ar_ad <= 1'b1;
		ic_ad <= 1'b1;
		barnb <= 1'b0;
		repeat (4) @(posedge __clk);
		rst_n <= 1'b1;
		@(posedge __clk);
		after_reset <= 1'b0;

		run_register_loads();
		run_alu_ops();
		run_at_and_wzi();
		run_increments();
		run_address_match();

		@(posedge __clk);
		idle_controls();
		repeat (2) @(posedge __clk);
		$display("errors: %0d value mismatches, %0d assertion failures",
			value_errors, UUT.u_regs.u_assertions.fail_count);
		if (value_errors == 0 && UUT.u_regs.u_assertions.fail_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- pa.f
hw/pa_word_pkg.sv
hw/pa_op_pkg.sv
hw/pa_decode.sv
hw/pa_bus.sv
hw/pa_alu.sv
hw/pa_regs.sv
hw/pa_result.sv
hw/pa.sv
tests/pa_assertions.sv
tests/pa_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the arithmetic unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module pa_tb \
	-f pa.f -o Vpa_tb
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/Vpa_tb +verilator+error+limit+100 > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -qx "=== PASS ===" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
